// File: hw/l2c_pkg.sv
// l2c tile init shared definitions
// layer codes, slot count, word width, register map and field positions

package l2c_pkg;

    localparam int L2C_WORD_W   = 32;
    localparam int L2C_NUM_SLOT = 32;

    // codes 2 and 3 are not supported by the sequencer
    typedef enum logic [1:0] {
        LAYER_POINTWISE = 2'd0,
        LAYER_DEPTHWISE = 2'd1
    } layer_type_e;

    // register word indices on wb_adr_i
    localparam logic [7:0] REG_CTRL       = 8'h00;
    localparam logic [7:0] REG_IFMAP_BASE = 8'h01;
    localparam logic [7:0] REG_IPSUM_BASE = 8'h02;
    localparam logic [7:0] REG_BIAS_BASE  = 8'h03;
    localparam logic [7:0] REG_OPSUM_BASE = 8'h04;
    localparam logic [7:0] REG_TILE_N     = 8'h05;
    localparam logic [7:0] REG_GEOM       = 8'h06;
    localparam logic [7:0] REG_ON_REAL    = 8'h07;

    // 32-word readback windows into the address table
    localparam logic [7:0] TBL_IFMAP = 8'h20;
    localparam logic [7:0] TBL_IPSUM = 8'h40;
    localparam logic [7:0] TBL_OPSUM = 8'h60;

    // ctrl word
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_BIAS_BIT  = 1;
    localparam int CTRL_LAYER_LSB = 2;
    localparam int CTRL_BUSY_BIT  = 8;
    localparam int CTRL_DONE_BIT  = 9;

    // geom word
    localparam int GEOM_IN_C_LSB  = 0;
    localparam int GEOM_PAD_R_LSB = 8;
    localparam int GEOM_PAD_L_LSB = 10;

endpackage

// File: hw/l2c_cfg_regs.sv
`timescale 1ns/1ns
// l2c configuration registers
// wishbone classic slave holding the tile configuration and the ctrl word,
// issues the start pulse and reads back the base address table

module l2c_cfg_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [7:0]                     wb_adr_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] wb_dat_i,
    input  logic [3:0]                     wb_sel_i,
    output logic [l2c_pkg::L2C_WORD_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           start_o,
    output logic [1:0]                     layer_type_o,
    output logic                           is_bias_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] ifmap_base_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] ipsum_base_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] bias_base_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] opsum_base_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] tile_n_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] on_real_o,
    output logic [7:0]                     in_c_o,
    output logic [1:0]                     pad_r_o,
    output logic [1:0]                     pad_l_o,
    input  logic                           busy_i,
    output logic [1:0]                     rd_kind_o,
    output logic [4:0]                     rd_slot_o,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] rd_data_i
);
    import l2c_pkg::*;

    logic                  req;
    logic                  busy_q;
    logic                  done_q;
    logic [L2C_WORD_W-1:0] rd_word;

    // new request only while no ack is out, so ack stays one cycle wide.
    // wb_sel_i is not decoded, every access is a full word
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_o <= 1'b0;
            start_o  <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            wb_ack_o <= req;
            start_o  <= req && wb_we_i && (wb_adr_i == REG_CTRL) &&
                        wb_dat_i[CTRL_START_BIT] && !busy_i;
            busy_q   <= busy_i;
            // sticky done on the falling edge of busy
            if (busy_q && !busy_i) begin
                done_q <= 1'b1;
            end
            if (start_o) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_type_o <= '0;
            is_bias_o    <= 1'b0;
            ifmap_base_o <= '0;
            ipsum_base_o <= '0;
            bias_base_o  <= '0;
            opsum_base_o <= '0;
            tile_n_o     <= '0;
            on_real_o    <= '0;
            in_c_o       <= '0;
            pad_r_o      <= '0;
            pad_l_o      <= '0;
        end else if (req && wb_we_i) begin
            case (wb_adr_i)
                REG_CTRL: begin
                    is_bias_o    <= wb_dat_i[CTRL_BIAS_BIT];
                    layer_type_o <= wb_dat_i[CTRL_LAYER_LSB +: 2];
                end
                REG_IFMAP_BASE: ifmap_base_o <= wb_dat_i;
                REG_IPSUM_BASE: ipsum_base_o <= wb_dat_i;
                REG_BIAS_BASE:  bias_base_o  <= wb_dat_i;
                REG_OPSUM_BASE: opsum_base_o <= wb_dat_i;
                REG_TILE_N:     tile_n_o     <= wb_dat_i;
                REG_ON_REAL:    on_real_o    <= wb_dat_i;
                REG_GEOM: begin
                    in_c_o  <= wb_dat_i[GEOM_IN_C_LSB +: 8];
                    pad_r_o <= wb_dat_i[GEOM_PAD_R_LSB +: 2];
                    pad_l_o <= wb_dat_i[GEOM_PAD_L_LSB +: 2];
                end
                default: ;
            endcase
        end
    end

    // table window decode, kind 3 means no table hit
    always_comb begin
        case (wb_adr_i & 8'he0)
            TBL_IFMAP: rd_kind_o = 2'd0;
            TBL_IPSUM: rd_kind_o = 2'd1;
            TBL_OPSUM: rd_kind_o = 2'd2;
            default:   rd_kind_o = 2'd3;
        endcase
    end

    assign rd_slot_o = wb_adr_i[4:0];

    always_comb begin
        rd_word = '0;
        case (wb_adr_i)
            REG_CTRL: begin
                rd_word[CTRL_BIAS_BIT]       = is_bias_o;
                rd_word[CTRL_LAYER_LSB +: 2] = layer_type_o;
                rd_word[CTRL_BUSY_BIT]       = busy_i;
                rd_word[CTRL_DONE_BIT]       = done_q;
            end
            REG_IFMAP_BASE: rd_word = ifmap_base_o;
            REG_IPSUM_BASE: rd_word = ipsum_base_o;
            REG_BIAS_BASE:  rd_word = bias_base_o;
            REG_OPSUM_BASE: rd_word = opsum_base_o;
            REG_TILE_N:     rd_word = tile_n_o;
            REG_ON_REAL:    rd_word = on_real_o;
            REG_GEOM: begin
                rd_word[GEOM_IN_C_LSB +: 8]  = in_c_o;
                rd_word[GEOM_PAD_R_LSB +: 2] = pad_r_o;
                rd_word[GEOM_PAD_L_LSB +: 2] = pad_l_o;
            end
            // table returns 0 outside its windows
            default: rd_word = rd_data_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_dat_o <= '0;
        end else if (req && !wb_we_i) begin
            wb_dat_o <= rd_word;
        end
    end

endmodule

// File: hw/l2c_init_fifo_pe.sv
`timescale 1ns/1ns
// l2c fifo and pe init sequencer
// holds the fifos in reset while a two-stage pipeline walks every slot
// and writes the ifmap, ipsum and opsum base addresses to the table

module l2c_init_fifo_pe #(
    parameter int NUM_SLOT = l2c_pkg::L2C_NUM_SLOT
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  logic [1:0]                     layer_type_i,
    input  logic                           is_bias_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] ifmap_base_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] ipsum_base_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] bias_base_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] opsum_base_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] tile_n_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] on_real_i,
    input  logic [7:0]                     in_c_i,
    input  logic [1:0]                     pad_r_i,
    input  logic [1:0]                     pad_l_i,
    output logic                           busy_o,
    output logic                           fifo_reset_o,
    output logic                           wr_en_o,
    output logic [$clog2(NUM_SLOT)-1:0]    wr_slot_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] ifmap_addr_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] ipsum_addr_o,
    output logic [l2c_pkg::L2C_WORD_W-1:0] opsum_addr_o
);
    import l2c_pkg::*;

    localparam int SLOT_W = $clog2(NUM_SLOT);
    // depthwise uses whole channels of three rows only
    localparam int DW_CH  = NUM_SLOT / 3;

    logic                  accept;
    logic                  busy_q;
    logic                  walk_q;
    logic [SLOT_W-1:0]     slot_q;
    logic [SLOT_W-1:0]     ch_q;
    logic [1:0]            row_q;
    logic [L2C_WORD_W-1:0] in_c_w;
    logic [L2C_WORD_W-1:0] row_w;
    logic [L2C_WORD_W-1:0] ch_idx;
    logic [L2C_WORD_W-1:0] row_idx;

    logic                  dw_q;
    logic                  supported_q;
    logic [L2C_WORD_W-1:0] if_base_q;
    logic [L2C_WORD_W-1:0] ip_base_q;
    logic [L2C_WORD_W-1:0] op_base_q;
    logic [L2C_WORD_W-1:0] if_ch_step_q;
    logic [L2C_WORD_W-1:0] ip_ch_step_q;
    logic [L2C_WORD_W-1:0] op_ch_step_q;
    logic [L2C_WORD_W-1:0] if_row_step_q;
    logic [L2C_WORD_W-1:0] ps_row_step_q;

    logic                  s1_vld_q;
    logic                  s1_keep_q;
    logic [SLOT_W-1:0]     s1_slot_q;
    logic [L2C_WORD_W-1:0] s1_if_ch_q;
    logic [L2C_WORD_W-1:0] s1_ip_ch_q;
    logic [L2C_WORD_W-1:0] s1_op_ch_q;
    logic [L2C_WORD_W-1:0] s1_if_row_q;
    logic [L2C_WORD_W-1:0] s1_ps_row_q;

    assign accept = start_i && !busy_q;
    assign in_c_w = L2C_WORD_W'(in_c_i);
    assign row_w  = in_c_w + L2C_WORD_W'(pad_r_i) + L2C_WORD_W'(pad_l_i);

    // snapshot, resolve ipsum base and the per-channel and per-row steps.
    // pointwise has a zero row step, so the channel index is the slot
    always_ff @(posedge clk) begin
        if (accept) begin
            dw_q        <= (layer_type_i == LAYER_DEPTHWISE);
            supported_q <= (layer_type_i == LAYER_POINTWISE) ||
                           (layer_type_i == LAYER_DEPTHWISE);
            if_base_q   <= ifmap_base_i;
            ip_base_q   <= is_bias_i ? bias_base_i : ipsum_base_i;
            op_base_q   <= opsum_base_i;
            if (layer_type_i == LAYER_DEPTHWISE) begin
                if_ch_step_q  <= tile_n_i * row_w;
                ip_ch_step_q  <= tile_n_i * in_c_w;
                op_ch_step_q  <= on_real_i * in_c_w;
                if_row_step_q <= row_w;
                ps_row_step_q <= in_c_w;
            end else begin
                if_ch_step_q  <= tile_n_i;
                ip_ch_step_q  <= tile_n_i;
                op_ch_step_q  <= on_real_i;
                if_row_step_q <= '0;
                ps_row_step_q <= '0;
            end
        end
    end

    // slot walk with channel and row kept alongside
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            walk_q <= 1'b0;
            slot_q <= '0;
            ch_q   <= '0;
            row_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            walk_q <= 1'b1;
            slot_q <= '0;
            ch_q   <= '0;
            row_q  <= '0;
        end else begin
            // busy ends with the write of the last slot
            if (wr_en_o && (wr_slot_o == SLOT_W'(NUM_SLOT - 1))) begin
                busy_q <= 1'b0;
            end
            if (walk_q) begin
                slot_q <= slot_q + 1'b1;
                walk_q <= (slot_q != SLOT_W'(NUM_SLOT - 1));
                if (row_q == 2'd2) begin
                    row_q <= 2'd0;
                    ch_q  <= ch_q + 1'b1;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld_q <= 1'b0;
            wr_en_o  <= 1'b0;
        end else begin
            s1_vld_q <= walk_q;
            wr_en_o  <= s1_vld_q;
        end
    end

    assign ch_idx  = dw_q ? L2C_WORD_W'(ch_q) : L2C_WORD_W'(slot_q);
    assign row_idx = L2C_WORD_W'(row_q);

    // stage 1, channel and row offset terms
    always_ff @(posedge clk) begin
        s1_slot_q   <= slot_q;
        s1_keep_q   <= supported_q && (!dw_q || (int'(ch_q) < DW_CH));
        s1_if_ch_q  <= ch_idx * if_ch_step_q;
        s1_ip_ch_q  <= ch_idx * ip_ch_step_q;
        s1_op_ch_q  <= ch_idx * op_ch_step_q;
        s1_if_row_q <= row_idx * if_row_step_q;
        s1_ps_row_q <= row_idx * ps_row_step_q;
    end

    // stage 2, add the bases and zero the unused slots
    always_ff @(posedge clk) begin
        wr_slot_o    <= s1_slot_q;
        ifmap_addr_o <= s1_keep_q ? if_base_q + s1_if_ch_q + s1_if_row_q : '0;
        ipsum_addr_o <= s1_keep_q ? ip_base_q + s1_ip_ch_q + s1_ps_row_q : '0;
        opsum_addr_o <= s1_keep_q ? op_base_q + s1_op_ch_q + s1_ps_row_q : '0;
    end

    assign busy_o       = busy_q;
    assign fifo_reset_o = busy_q;

endmodule

// File: hw/l2c_base_addr_table.sv
`timescale 1ns/1ns
// l2c base address table
// ifmap, ipsum and opsum slot addresses, written together per slot
// by the sequencer and read back combinationally over the bus

module l2c_base_addr_table #(
    parameter int NUM_SLOT = l2c_pkg::L2C_NUM_SLOT
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en_i,
    input  logic [$clog2(NUM_SLOT)-1:0]    wr_slot_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] ifmap_addr_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] ipsum_addr_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] opsum_addr_i,
    input  logic [1:0]                     rd_kind_i,
    input  logic [4:0]                     rd_slot_i,
    output logic [l2c_pkg::L2C_WORD_W-1:0] rd_data_o
);
    import l2c_pkg::*;

    localparam int SLOT_W = $clog2(NUM_SLOT);

    // bank 0 ifmap, 1 ipsum, 2 opsum
    logic [L2C_WORD_W-1:0] bank [3][NUM_SLOT];
    logic [SLOT_W-1:0]     rd_idx;
    logic                  rd_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 3; k++) begin
                for (int s = 0; s < NUM_SLOT; s++) begin
                    bank[k][s] <= '0;
                end
            end
        end else if (wr_en_i) begin
            bank[0][wr_slot_i] <= ifmap_addr_i;
            bank[1][wr_slot_i] <= ipsum_addr_i;
            bank[2][wr_slot_i] <= opsum_addr_i;
        end
    end

    // kind 3 and slots past NUM_SLOT read as zero
    assign rd_idx = rd_slot_i[SLOT_W-1:0];
    assign rd_hit = (rd_kind_i != 2'd3) && (int'(rd_slot_i) < NUM_SLOT);

    always_comb begin
        rd_data_o = '0;
        if (rd_hit) begin
            rd_data_o = bank[rd_kind_i][rd_idx];
        end
    end

endmodule

// File: hw/l2c_tile_init_top.sv
`timescale 1ns/1ns
// l2c tile init subsystem
// register block, init sequencer and base address table

module l2c_tile_init_top #(
    parameter int NUM_SLOT = l2c_pkg::L2C_NUM_SLOT
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [7:0]                     wb_adr_i,
    input  logic [l2c_pkg::L2C_WORD_W-1:0] wb_dat_i,
    input  logic [3:0]                     wb_sel_i,
    output logic [l2c_pkg::L2C_WORD_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           fifo_reset_o
);
    import l2c_pkg::*;

    localparam int SLOT_W = $clog2(NUM_SLOT);

    logic                  start;
    logic [1:0]            layer_type;
    logic                  is_bias;
    logic [L2C_WORD_W-1:0] ifmap_base;
    logic [L2C_WORD_W-1:0] ipsum_base;
    logic [L2C_WORD_W-1:0] bias_base;
    logic [L2C_WORD_W-1:0] opsum_base;
    logic [L2C_WORD_W-1:0] tile_n;
    logic [L2C_WORD_W-1:0] on_real;
    logic [7:0]            in_c;
    logic [1:0]            pad_r;
    logic [1:0]            pad_l;
    logic                  busy;
    logic [1:0]            rd_kind;
    logic [4:0]            rd_slot;
    logic [L2C_WORD_W-1:0] rd_data;
    logic                  wr_en;
    logic [SLOT_W-1:0]     wr_slot;
    logic [L2C_WORD_W-1:0] ifmap_addr;
    logic [L2C_WORD_W-1:0] ipsum_addr;
    logic [L2C_WORD_W-1:0] opsum_addr;

    l2c_cfg_regs u_cfg_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .start_o      (start),
        .layer_type_o (layer_type),
        .is_bias_o    (is_bias),
        .ifmap_base_o (ifmap_base),
        .ipsum_base_o (ipsum_base),
        .bias_base_o  (bias_base),
        .opsum_base_o (opsum_base),
        .tile_n_o     (tile_n),
        .on_real_o    (on_real),
        .in_c_o       (in_c),
        .pad_r_o      (pad_r),
        .pad_l_o      (pad_l),
        .busy_i       (busy),
        .rd_kind_o    (rd_kind),
        .rd_slot_o    (rd_slot),
        .rd_data_i    (rd_data)
    );

    l2c_init_fifo_pe #(
        .NUM_SLOT (NUM_SLOT)
    ) u_init_fifo_pe (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .layer_type_i (layer_type),
        .is_bias_i    (is_bias),
        .ifmap_base_i (ifmap_base),
        .ipsum_base_i (ipsum_base),
        .bias_base_i  (bias_base),
        .opsum_base_i (opsum_base),
        .tile_n_i     (tile_n),
        .on_real_i    (on_real),
        .in_c_i       (in_c),
        .pad_r_i      (pad_r),
        .pad_l_i      (pad_l),
        .busy_o       (busy),
        .fifo_reset_o (fifo_reset_o),
        .wr_en_o      (wr_en),
        .wr_slot_o    (wr_slot),
        .ifmap_addr_o (ifmap_addr),
        .ipsum_addr_o (ipsum_addr),
        .opsum_addr_o (opsum_addr)
    );

    l2c_base_addr_table #(
        .NUM_SLOT (NUM_SLOT)
    ) u_base_addr_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en_i      (wr_en),
        .wr_slot_i    (wr_slot),
        .ifmap_addr_i (ifmap_addr),
        .ipsum_addr_i (ipsum_addr),
        .opsum_addr_i (opsum_addr),
        .rd_kind_i    (rd_kind),
        .rd_slot_i    (rd_slot),
        .rd_data_o    (rd_data)
    );

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ns
// testbench clock and reset
// free running clock, reset held low for a few cycles then released

module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: bench/l2c_init_props.sv
`timescale 1ns/1ns
// l2c tile init bus and sequencer properties
// one-cycle wishbone ack, fifo reset tracking busy, table writes only while busy

module l2c_init_props (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic fifo_reset_o,
    input logic busy,
    input logic wr_en
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o held high for more than one cycle");

    // ack only answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o without a preceding cyc and stb");

    fifo_reset_busy: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_reset_o == busy)
        else $error("fifo_reset_o differs from busy");

    wr_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> busy)
        else $error("table write outside a busy window");

endmodule

bind l2c_tile_init_top l2c_init_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_o     (wb_ack_o),
    .fifo_reset_o (fifo_reset_o),
    .busy         (busy),
    .wr_en        (wr_en)
);

// File: bench/tb_l2c_tile_init.sv
`timescale 1ns/1ns
// testbench for the l2c tile init subsystem
// random tile configurations over wishbone, table readback against an address model

module tb_l2c_tile_init;
    import l2c_pkg::*;

    localparam int NUM_SLOT   = 32;
    localparam int BUS_LIMIT  = 20;
    localparam int POLL_LIMIT = 100;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [7:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        fifo_reset_o;

    logic [15:0] lfsr;
    int          fail_cnt;
    int          check_cnt;
    int          test_fail;
    int          fifo_hi_cnt = 0;

    // configuration of the run being checked
    logic [31:0] c_if, c_ip, c_bias, c_op, c_tile, c_on;
    logic [7:0]  c_in_c;
    logic [1:0]  c_pad_r, c_pad_l, c_layer;
    logic        c_bias_sel;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    l2c_tile_init_top #(.NUM_SLOT(NUM_SLOT)) UUT (
        .clk(clk), .rst_n(rst_n), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_sel_i(wb_sel_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .fifo_reset_o(fifo_reset_o)
    );

    always @(negedge clk) begin
        if (fifo_reset_o) begin
            fifo_hi_cnt++;
        end
    end

    // galois lfsr with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hB400;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [31:0] model_addr(input int kind, input int k);
        logic [31:0] w, c, r, kk, in_c, b_ip;
        in_c = 32'(c_in_c);
        w    = in_c + 32'(c_pad_r) + 32'(c_pad_l);
        b_ip = c_bias_sel ? c_bias : c_ip;
        kk   = 32'(k);
        c    = 32'(k / 3);
        r    = 32'(k % 3);
        if (c_layer == 2'd0) begin
            case (kind)
                0:       return c_if + kk * c_tile;
                1:       return b_ip + kk * c_tile;
                default: return c_op + kk * c_on;
            endcase
        end else if (c_layer == 2'd1 && k < 3 * (NUM_SLOT / 3)) begin
            case (kind)
                0:       return c_if + c * c_tile * w + r * w;
                1:       return b_ip + c * c_tile * in_c + r * in_c;
                default: return c_op + c * c_on * in_c + r * in_c;
            endcase
        end
        return '0;
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d", check_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s did not happen in time", what);
        fail_cnt++;
        test_fail++;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            fail_cnt++;
            test_fail++;
            $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic end_test(input string title);
        $display("%-30s %0d errors", title, test_fail);
        test_fail = 0;
    endtask

    // drives one classic cycle on the falling edge and takes the data while ack is high
    task automatic bus_access(input logic we, input logic [7:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = 4'hf;
        n = 0;
        while (!wb_ack_o && n < BUS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!wb_ack_o) begin
            timed_out("wishbone ack");
        end
    endtask

    task automatic read_check(input logic [7:0] adr, input logic [31:0] exp);
        logic [31:0] d;
        bus_access(1'b0, adr, '0, d);
        check_word($sformatf("wb_dat_o @0x%02h", adr), d, exp);
    endtask

    task automatic random_config(input logic [1:0] layer, input logic bias_sel);
        c_if       = rand_bits(32);
        c_ip       = rand_bits(32);
        c_bias     = rand_bits(32);
        c_op       = rand_bits(32);
        c_tile     = rand_bits(32);
        c_on       = rand_bits(32);
        c_in_c     = 8'(rand_bits(8));
        c_pad_r    = 2'(rand_bits(2));
        c_pad_l    = 2'(rand_bits(2));
        c_layer    = layer;
        c_bias_sel = bias_sel;
    endtask

    task automatic write_config();
        logic [31:0] d;
        bus_access(1'b1, REG_IFMAP_BASE, c_if, d);
        bus_access(1'b1, REG_IPSUM_BASE, c_ip, d);
        bus_access(1'b1, REG_BIAS_BASE, c_bias, d);
        bus_access(1'b1, REG_OPSUM_BASE, c_op, d);
        bus_access(1'b1, REG_TILE_N, c_tile, d);
        bus_access(1'b1, REG_ON_REAL, c_on, d);
        bus_access(1'b1, REG_GEOM, {20'h0, c_pad_l, c_pad_r, c_in_c}, d);
    endtask

    task automatic start_run();
        logic [31:0] d;
        bus_access(1'b1, REG_CTRL, {28'h0, c_layer, c_bias_sel, 1'b1}, d);
    endtask

    task automatic wait_done();
        int          polls;
        logic [31:0] d;
        polls = 0;
        d = '0;
        while (!d[CTRL_DONE_BIT] && polls < POLL_LIMIT) begin
            bus_access(1'b0, REG_CTRL, '0, d);
            polls++;
        end
        if (!d[CTRL_DONE_BIT]) begin
            timed_out("done flag");
        end
    endtask

    task automatic check_table();
        logic [7:0] base;
        for (int kind = 0; kind < 3; kind++) begin
            base = (kind == 0) ? TBL_IFMAP : (kind == 1) ? TBL_IPSUM : TBL_OPSUM;
            for (int k = 0; k < NUM_SLOT; k++) begin
                read_check(base + 8'(k), model_addr(kind, k));
            end
        end
    endtask

    task automatic run_and_check();
        write_config();
        start_run();
        wait_done();
        check_table();
        // start reads back as 0 with done set and busy clear
        read_check(REG_CTRL, 32'h200 | {28'h0, c_layer, c_bias_sel, 1'b0});
    endtask

    initial begin
        int          n;
        int          hi_before;
        logic [31:0] d;
        logic [31:0] v;
        lfsr      = 16'd56198;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        wb_sel_i  = '0;
        fail_cnt  = 0;
        check_cnt = 0;
        test_fail = 0;
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timed_out("reset release");
        end

        check_word("fifo_reset_o", 32'(fifo_reset_o), 32'h0);
        read_check(REG_CTRL, 32'h0);
        for (int k = 0; k < NUM_SLOT; k += 13) begin
            read_check(TBL_IFMAP + 8'(k), 32'h0);
            read_check(TBL_IPSUM + 8'(k), 32'h0);
            read_check(TBL_OPSUM + 8'(k), 32'h0);
        end
        end_test("1 after reset");

        for (int a = 0; a < 8; a++) begin
            v = rand_bits(32);
            if (a == 0) begin
                // keep start clear so no run begins
                v = v & ~32'h1;
            end
            bus_access(1'b1, 8'(a), v, d);
            if (a == 0) begin
                read_check(8'(a), v & 32'h0000_000e);
            end else if (8'(a) == REG_GEOM) begin
                read_check(8'(a), v & 32'h0000_0fff);
            end else begin
                read_check(8'(a), v);
            end
        end
        bus_access(1'b1, 8'h10, 32'hffff_ffff, d);
        read_check(8'h10, 32'h0);
        end_test("2 register access");

        random_config(LAYER_POINTWISE, 1'b0);
        run_and_check();
        random_config(LAYER_POINTWISE, 1'b1);
        run_and_check();
        end_test("3 pointwise init");

        random_config(LAYER_DEPTHWISE, 1'b0);
        run_and_check();
        random_config(LAYER_DEPTHWISE, 1'b1);
        run_and_check();
        end_test("4 depthwise init");

        random_config(2'd2, 1'b0);
        run_and_check();
        random_config(LAYER_POINTWISE, 1'b0);
        write_config();
        start_run();
        // new values while the first run is still going
        bus_access(1'b1, REG_IFMAP_BASE, ~c_if, d);
        bus_access(1'b1, REG_TILE_N, c_tile + 32'd1, d);
        bus_access(1'b0, REG_CTRL, '0, d);
        check_word("ctrl busy bit", 32'(d[CTRL_BUSY_BIT]), 32'h1);
        bus_access(1'b1, REG_CTRL, 32'h0000_0007, d);
        wait_done();
        check_table();
        end_test("5 unsupported and ignored start");

        random_config(LAYER_POINTWISE, 1'b1);
        write_config();
        hi_before = fifo_hi_cnt;
        start_run();
        wait_done();
        check_word("fifo_reset_o seen high", 32'(fifo_hi_cnt > hi_before), 32'h1);
        check_word("fifo_reset_o", 32'(fifo_reset_o), 32'h0);
        end_test("6 fifo reset");

        finish_run();
    end

endmodule

// File: l2c_tile_init.f
hw/l2c_pkg.sv
hw/l2c_cfg_regs.sv
hw/l2c_init_fifo_pe.sv
hw/l2c_base_addr_table.sv
hw/l2c_tile_init_top.sv
bench/tb_clk_gen.sv
bench/l2c_init_props.sv
bench/tb_l2c_tile_init.sv

// File: run.sh
#!/usr/bin/env bash
# build the l2c tile init testbench with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log
TOP=tb_l2c_tile_init

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f l2c_tile_init.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
